/* source/svPagingPkg.sv */
// Sv32 only, 32-bit physical addresses so PTE bits 31:30 are ignored and the PPN is 20 bits
package svPagingPkg;

	//////////////////////////////////////////////////////////////////////
	// page numbers
	//////////////////////////////////////////////////////////////////////

	typedef logic [19:0] vpnT;	// vpn[1] in 19:10, vpn[0] in 9:0
	typedef logic [19:0] ppnT;	// 32-bit PA -> 20-bit ppn

	// megapage is a level-1 leaf covering 4 MiB
	typedef enum logic {
		KILOPAGE = 1'b0,
		MEGAPAGE = 1'b1
	} pageTypeT;

	typedef enum logic {
		ACC_READ  = 1'b0,
		ACC_WRITE = 1'b1
	} accessT;

	// walker FSM
	// REQ states set up the bus address, WAIT states hold the Wishbone cycle
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		L1_REQ  = 3'd1,
		L1_WAIT = 3'd2,
		L0_REQ  = 3'd3,
		L0_WAIT = 3'd4,
		FILL    = 3'd5,
		FAULT   = 3'd6
	} walkStateT;

	//////////////////////////////////////////////////////////////////////
	// PTE bit positions
	//////////////////////////////////////////////////////////////////////

	localparam int pteV = 0;
	localparam int pteR = 1;
	localparam int pteW = 2;
	localparam int pteX = 3;
	localparam int pteA = 6;
	localparam int pteD = 7;
	localparam int ptePpnLsb = 10;	// ppn field runs 31:10, only 29:10 used here

endpackage

/* source/wbBusPkg.sv */
// Wishbone classic read-only subset, 32-bit address and data, no byte selects or bursts
package wbBusPkg;

	typedef logic [31:0] wbAdrT;	// byte address, word aligned for PTE reads
	typedef logic [31:0] wbDatT;

	// master side view of a bus cycle
	// BUSY covers the whole cyc/stb window up to and including the ack cycle
	typedef enum logic {
		WB_IDLE = 1'b0,
		WB_BUSY = 1'b1
	} wbCycleT;

endpackage

/* source/walkReqIf.sv */
// walk request (valid/ready) and TLB fill (single-cycle pulse, no back-pressure) bundles
`timescale 1ns/100ps

interface walkReqIf;

	// request bundle, transfers when reqValid and reqReady are both high
	logic reqValid;
	logic reqReady;
	svPagingPkg::vpnT reqVpn;
	svPagingPkg::accessT reqAccess;

	// fill bundle, one-cycle pulse from walker to TLB
	logic fillValid;
	svPagingPkg::vpnT fillVpn;
	svPagingPkg::ppnT fillPpn;
	svPagingPkg::pageTypeT fillType;
	logic fillRead;
	logic fillWrite;
	logic fillDirty;

	modport reqSource (
		output reqValid, reqVpn, reqAccess,
		input  reqReady
	);

	modport reqSink (
		input  reqValid, reqVpn, reqAccess,
		output reqReady
	);

	modport fillSource (
		output fillValid, fillVpn, fillPpn, fillType, fillRead, fillWrite, fillDirty
	);

	modport fillSink (
		input  fillValid, fillVpn, fillPpn, fillType, fillRead, fillWrite, fillDirty
	);

endinterface

/* source/tlb.sv */
// fully associative, one-cycle lookup, one client, misses are reported and the client must retry
`timescale 1ns/100ps

module tlb #(
	parameter int tlbEntries = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic flushTlb,
	input  logic lookupValid,
	input  logic [31:0] lookupVadr,
	input  svPagingPkg::accessT lookupAccess,
	output logic lookupDone,
	output logic lookupHit,
	output logic lookupFault,
	output logic [31:0] lookupPadr,
	walkReqIf.reqSource missPort,
	walkReqIf.fillSink fillPort
);

	localparam int idxW = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;

	// entry storage, only entValid is control state
	logic entValid [tlbEntries];
	svPagingPkg::vpnT entVpn [tlbEntries];
	svPagingPkg::ppnT entPpn [tlbEntries];
	svPagingPkg::pageTypeT entType [tlbEntries];
	logic entRead [tlbEntries];
	logic entWrite [tlbEntries];
	logic entDirty [tlbEntries];

	svPagingPkg::vpnT lookVpn;
	logic [tlbEntries-1:0] lookMatch;	// entries hit by the lookup
	logic [tlbEntries-1:0] fillMatch;	// entries overlapping the incoming fill
	logic [idxW-1:0] hitIdx, fillIdx, fillSlot, victim;
	logic anyMatch, anyFill, permOk, missNew;
	logic [31:0] hitPadr;

	assign lookVpn = lookupVadr[31:12];

	//////////////////////////////////////////////////////////////////////
	// tag compare
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < tlbEntries; i++) begin
			if (entType[i] == svPagingPkg::MEGAPAGE)	// megapage ignores vpn[0]
				lookMatch[i] = entValid[i] && (entVpn[i][19:10] == lookVpn[19:10]);
			else
				lookMatch[i] = entValid[i] && (entVpn[i] == lookVpn);
			// a megapage on either side overlaps on vpn[1] alone
			if (entType[i] == svPagingPkg::MEGAPAGE || fillPort.fillType == svPagingPkg::MEGAPAGE)
				fillMatch[i] = entValid[i] && (entVpn[i][19:10] == fillPort.fillVpn[19:10]);
			else
				fillMatch[i] = entValid[i] && (entVpn[i] == fillPort.fillVpn);
		end
	end

	// lowest matching index wins
	always_comb begin
		hitIdx = '0;
		fillIdx = '0;
		for (int i = tlbEntries - 1; i >= 0; i--) begin
			if (lookMatch[i])
				hitIdx = idxW'(i);
			if (fillMatch[i])
				fillIdx = idxW'(i);
		end
	end

	assign anyMatch = |lookMatch;
	assign anyFill = |fillMatch;
	assign fillSlot = anyFill ? fillIdx : victim;	// refill overwrites in place

	// Svade, a store needs W and an already set D
	assign permOk = (lookupAccess == svPagingPkg::ACC_WRITE) ?
		(entWrite[hitIdx] && entDirty[hitIdx]) : entRead[hitIdx];

	assign hitPadr = (entType[hitIdx] == svPagingPkg::MEGAPAGE) ?
		{entPpn[hitIdx][19:10], lookupVadr[21:0]} : {entPpn[hitIdx], lookupVadr[11:0]};

	// enqueue only when the miss slot is free or draining this cycle
	assign missNew = lookupValid && !anyMatch && !flushTlb &&
		(!missPort.reqValid || missPort.reqReady);

	//////////////////////////////////////////////////////////////////////
	// lookup result, one cycle after lookupValid
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			lookupDone <= 1'b0;
			lookupHit <= 1'b0;
			lookupFault <= 1'b0;
		end else begin
			lookupDone <= lookupValid;
			lookupHit <= lookupValid && anyMatch && permOk;
			lookupFault <= lookupValid && anyMatch && !permOk;
		end
	end

	always_ff @(posedge clk)
		if (lookupValid)
			lookupPadr <= hitPadr;

	// held miss request toward the queue, flush drops it
	always_ff @(posedge clk) begin
		if (reset || flushTlb)
			missPort.reqValid <= 1'b0;
		else if (missNew)
			missPort.reqValid <= 1'b1;
		else if (missPort.reqReady)
			missPort.reqValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (missNew) begin
			missPort.reqVpn <= lookVpn;
			missPort.reqAccess <= lookupAccess;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// fills
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || flushTlb) begin	// fill in the flush cycle is lost
			for (int i = 0; i < tlbEntries; i++)
				entValid[i] <= 1'b0;
		end else if (fillPort.fillValid) begin
			for (int i = 0; i < tlbEntries; i++)
				if (fillMatch[i])
					entValid[i] <= 1'b0;	// clear stale overlaps
			entValid[fillSlot] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fillPort.fillValid) begin
			entVpn[fillSlot] <= fillPort.fillVpn;
			entPpn[fillSlot] <= fillPort.fillPpn;
			entType[fillSlot] <= fillPort.fillType;
			entRead[fillSlot] <= fillPort.fillRead;
			entWrite[fillSlot] <= fillPort.fillWrite;
			entDirty[fillSlot] <= fillPort.fillDirty;
		end
	end

	// round-robin victim, steps on every accepted fill
	always_ff @(posedge clk) begin
		if (reset)
			victim <= '0;
		else if (fillPort.fillValid && !flushTlb)
			victim <= (victim == idxW'(tlbEntries - 1)) ? '0 : victim + 1'b1;
	end

	// fill overlap handling must keep every translation unique
	assert property (@(posedge clk) disable iff (reset) lookupValid |-> $onehot0(lookMatch))
		else $error("tlb: vpn %h matches more than one entry", lookVpn);

endmodule

/* source/walkQueue.sv */
// circular FIFO of walk requests, push and pop in one cycle allowed, no bypass from input to output
`timescale 1ns/100ps

module walkQueue #(
	parameter int queueDepth = 4
) (
	input  logic clk,
	input  logic reset,
	walkReqIf.reqSink inPort,
	walkReqIf.reqSource outPort
);

	localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int cntW = $clog2(queueDepth + 1);

	svPagingPkg::vpnT qVpn [queueDepth];
	svPagingPkg::accessT qAccess [queueDepth];

	logic [ptrW-1:0] rdPtr, wrPtr;
	logic [cntW-1:0] count;
	logic push, pop;

	assign inPort.reqReady = (count != cntW'(queueDepth));	// not full
	assign outPort.reqValid = (count != '0);
	assign outPort.reqVpn = qVpn[rdPtr];
	assign outPort.reqAccess = qAccess[rdPtr];

	assign push = inPort.reqValid && inPort.reqReady;
	assign pop = outPort.reqValid && outPort.reqReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	// storage, data shows at the output the cycle after the push
	always_ff @(posedge clk) begin
		if (push) begin
			qVpn[wrPtr] <= inPort.reqVpn;
			qAccess[wrPtr] <= inPort.reqAccess;
		end
	end

	// full queue must refuse the TLB
	assert property (@(posedge clk) disable iff (reset) push |-> count < cntW'(queueDepth))
		else $error("walkQueue: push accepted while full");

	assert property (@(posedge clk) disable iff (reset) count <= cntW'(queueDepth))
		else $error("walkQueue: count %0d above depth", count);

endmodule

/* source/hptw.sv */
// Sv32 two-level walker, reads only (Svade, no A/D update), one walk at a time, ignores flush
`timescale 1ns/100ps

module hptw (
	input  logic clk,
	input  logic reset,
	input  svPagingPkg::ppnT satpPpn,	// root table
	input  wbBusPkg::wbDatT wbDat,
	input  logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output wbBusPkg::wbAdrT wbAdr,
	output logic walkFault,
	output logic [31:0] faultVadr,
	walkReqIf walkPort	// request sink and fill source
);

	svPagingPkg::walkStateT state, nextState;
	wbBusPkg::wbCycleT busState;

	svPagingPkg::vpnT walkVpn;	// page being walked
	svPagingPkg::accessT walkAccess;
	wbBusPkg::wbDatT walkPte;	// last PTE read
	svPagingPkg::pageTypeT walkType;

	logic startWalk;
	logic atLevel1;
	logic pteLeaf, pteBad;
	logic ackSeen;

	assign walkPort.reqReady = (state == svPagingPkg::IDLE);
	assign startWalk = walkPort.reqValid && walkPort.reqReady;
	assign ackSeen = (busState == wbBusPkg::WB_BUSY) && wbAck;

	//////////////////////////////////////////////////////////////////////
	// PTE checks on the word coming back from the bus
	//////////////////////////////////////////////////////////////////////

	assign atLevel1 = (state == svPagingPkg::L1_WAIT);
	assign pteLeaf = wbDat[svPagingPkg::pteR] | wbDat[svPagingPkg::pteW] | wbDat[svPagingPkg::pteX];

	assign pteBad = !wbDat[svPagingPkg::pteV] ||
		(wbDat[svPagingPkg::pteW] && !wbDat[svPagingPkg::pteR]) ||	// reserved encoding
		(atLevel1 && pteLeaf && |wbDat[svPagingPkg::ptePpnLsb +: 10]) ||	// megapage misaligned
		(!atLevel1 && !pteLeaf) ||	// pointer at the last level
		(pteLeaf && !wbDat[svPagingPkg::pteA]);	// Svade, no hardware A update

	//////////////////////////////////////////////////////////////////////
	// walker FSM
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			svPagingPkg::IDLE:
				if (startWalk)
					nextState = svPagingPkg::L1_REQ;
			svPagingPkg::L1_REQ:
				nextState = svPagingPkg::L1_WAIT;
			svPagingPkg::L1_WAIT:
				if (ackSeen) begin
					if (pteBad)
						nextState = svPagingPkg::FAULT;
					else if (pteLeaf)
						nextState = svPagingPkg::FILL;	// megapage
					else
						nextState = svPagingPkg::L0_REQ;
				end
			svPagingPkg::L0_REQ:
				nextState = svPagingPkg::L0_WAIT;
			svPagingPkg::L0_WAIT:
				if (ackSeen)
					nextState = pteBad ? svPagingPkg::FAULT : svPagingPkg::FILL;
			default:
				nextState = svPagingPkg::IDLE;	// FILL, FAULT last one cycle
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= svPagingPkg::IDLE;
			busState <= wbBusPkg::WB_IDLE;
		end else begin
			state <= nextState;
			// REQ states open the bus cycle, ack closes it
			if (state == svPagingPkg::L1_REQ || state == svPagingPkg::L0_REQ)
				busState <= wbBusPkg::WB_BUSY;
			else if (ackSeen)
				busState <= wbBusPkg::WB_IDLE;
		end
	end

	// walk payload
	always_ff @(posedge clk) begin
		if (startWalk) begin
			walkVpn <= walkPort.reqVpn;
			walkAccess <= walkPort.reqAccess;
		end
		if (state == svPagingPkg::L1_REQ)
			wbAdr <= {satpPpn, walkVpn[19:10], 2'b00};
		if (state == svPagingPkg::L0_REQ)	// next table from the level-1 pointer
			wbAdr <= {walkPte[svPagingPkg::ptePpnLsb +: 20], walkVpn[9:0], 2'b00};
		if (ackSeen) begin
			walkPte <= wbDat;
			walkType <= atLevel1 ? svPagingPkg::MEGAPAGE : svPagingPkg::KILOPAGE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus, fill and fault outputs
	//////////////////////////////////////////////////////////////////////

	assign wbCyc = (busState == wbBusPkg::WB_BUSY);
	assign wbStb = (busState == wbBusPkg::WB_BUSY);	// single read, stb tracks cyc

	assign walkPort.fillValid = (state == svPagingPkg::FILL);
	assign walkPort.fillVpn = walkVpn;
	assign walkPort.fillPpn = walkPte[svPagingPkg::ptePpnLsb +: 20];
	assign walkPort.fillType = walkType;
	assign walkPort.fillRead = walkPte[svPagingPkg::pteR];
	assign walkPort.fillWrite = walkPte[svPagingPkg::pteW];
	assign walkPort.fillDirty = walkPte[svPagingPkg::pteD];

	assign walkFault = (state == svPagingPkg::FAULT);
	assign faultVadr = {walkVpn, 12'h000};	// page base

	// a stalled read keeps its strobe, cycle and address until ack
	assert property (@(posedge clk) disable iff (reset)
		wbStb && !wbAck |=> wbStb && wbCyc && $stable(wbAdr))
		else $error("hptw: Wishbone read dropped or changed before ack");

	// every walk ends in a fill or a fault, never both
	assert property (@(posedge clk) disable iff (reset)
		!(walkPort.fillValid && walkFault))
		else $error("hptw: fill and fault together for %s walk", walkAccess.name());

endmodule

/* source/mmuTop.sv */
// Sv32 MMU top, one TLB client, read-only Wishbone classic master, satpPpn must stay stable during walks
`timescale 1ns/100ps

module mmuTop #(
	parameter int tlbEntries = 4,
	parameter int queueDepth = 4
) (
	input  logic clk,
	input  logic reset,
	input  svPagingPkg::ppnT satpPpn,
	input  logic flushTlb,
	// lookup side
	input  logic lookupValid,
	input  logic [31:0] lookupVadr,
	input  svPagingPkg::accessT lookupAccess,
	output logic lookupDone,
	output logic lookupHit,
	output logic lookupFault,
	output logic [31:0] lookupPadr,
	// Wishbone master, reads only
	output logic wbCyc,
	output logic wbStb,
	output wbBusPkg::wbAdrT wbAdr,
	input  wbBusPkg::wbDatT wbDat,
	input  logic wbAck,
	// walk faults
	output logic walkFault,
	output logic [31:0] faultVadr
);

	walkReqIf missLink ();	// tlb -> queue
	walkReqIf walkLink ();	// queue -> walker, fills walker -> tlb

	tlb #(
		.tlbEntries(tlbEntries)
	) tlbUnit (
		.clk,
		.reset,
		.flushTlb,
		.lookupValid,
		.lookupVadr,
		.lookupAccess,
		.lookupDone,
		.lookupHit,
		.lookupFault,
		.lookupPadr,
		.missPort(missLink.reqSource),
		.fillPort(walkLink.fillSink)
	);

	walkQueue #(
		.queueDepth(queueDepth)
	) missQueue (
		.clk,
		.reset,
		.inPort(missLink.reqSink),
		.outPort(walkLink.reqSource)
	);

	hptw walker (
		.clk,
		.reset,
		.satpPpn,
		.wbDat,
		.wbAck,
		.wbCyc,
		.wbStb,
		.wbAdr,
		.walkFault,
		.faultVadr,
		.walkPort(walkLink)
	);

endmodule

/* verification/mmuMemModel.sv */
// read-only Wishbone classic slave, 4096 words decoded from wbAdr[13:2] so upper address bits alias
`timescale 1ns/100ps

module mmuMemModel (
	input  logic clk,
	input  logic reset,
	input  logic wbCyc,
	input  logic wbStb,
	input  wbBusPkg::wbAdrT wbAdr,
	output wbBusPkg::wbDatT wbDat,
	output logic wbAck
);

	localparam logic [31:0] seed = 32'hb713fb6a;

	wbBusPkg::wbDatT mem [4096];	// page tables, loaded by the testbench
	wbBusPkg::wbCycleT busState;
	logic [31:0] rng;
	logic [1:0] waitLeft;	// wait states still to insert

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		for (int i = 0; i < 4096; i++)
			mem[i] = '0;	// V clear everywhere
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busState <= wbBusPkg::WB_IDLE;
			wbAck <= 1'b0;
			wbDat <= '0;
			rng <= seed;
			waitLeft <= '0;
		end else begin
			wbAck <= 1'b0;	// ack is a single-cycle pulse
			case (busState)
				wbBusPkg::WB_IDLE:
					if (wbCyc && wbStb && !wbAck) begin	// skip the cycle the master sees ack
						rng <= xorshift(rng);
						waitLeft <= rng[1:0];	// 0 to 3 wait states
						busState <= wbBusPkg::WB_BUSY;
					end
				default:
					if (waitLeft == 2'd0) begin
						wbAck <= 1'b1;
						wbDat <= mem[wbAdr[13:2]];
						busState <= wbBusPkg::WB_IDLE;
					end else
						waitLeft <= waitLeft - 1'b1;
			endcase
		end
	end

endmodule

/* verification/mmuTb.sv */
// directed tests for mmuTop with 4 TLB entries, root table at PPN 1, level-0 tables at PPN 2 and 3
`timescale 1ns/100ps

module mmuTb;

	localparam int clkPeriod = 20;
	localparam int walkBudget = 400;	// cycles allowed per walk
	localparam int totalWalks = 29;	// walks started over all tests
	localparam svPagingPkg::ppnT rootPpn = 20'h00001;
	localparam logic [7:0] flagV = 8'h01;
	localparam logic [7:0] flagR = 8'h02;
	localparam logic [7:0] flagW = 8'h04;
	localparam logic [7:0] flagA = 8'h40;
	localparam logic [7:0] flagD = 8'h80;
	localparam logic [7:0] flagsRwad = flagV | flagR | flagW | flagA | flagD;

	logic clk, reset, flushTlb, lookupValid;
	logic [31:0] lookupVadr;
	svPagingPkg::accessT lookupAccess;
	svPagingPkg::ppnT satpPpn;
	logic lookupDone, lookupHit, lookupFault;
	logic [31:0] lookupPadr;
	logic wbCyc, wbStb, wbAck, walkFault;
	wbBusPkg::wbAdrT wbAdr;
	wbBusPkg::wbDatT wbDat;
	logic [31:0] faultVadr;

	int fills = 0;	// completed walks seen so far
	int faults = 0;
	logic [31:0] lastFault = '0;
	logic ackLast = 1'b0;	// wbAck in the previous cycle

	mmuTop #(.tlbEntries(4), .queueDepth(4)) dut (.*);

	mmuMemModel memory (.clk, .reset, .wbCyc, .wbStb, .wbAdr, .wbDat, .wbAck);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// count walk endings, a fill is taken from the walker's fill bundle
	always @(posedge clk) begin
		if (walkFault) begin
			faults <= faults + 1;
			lastFault <= faultVadr;
		end
		if (dut.walkLink.fillValid)
			fills <= fills + 1;
	end

	// Wishbone classic master rules, all tables sit below 16 KiB
	always @(posedge clk) begin
		ackLast <= wbAck;
		if (!reset) begin
			assert (wbStb === wbCyc)
			else begin
				$display("wbStb and wbCyc differ at %0t ns", $time);
				stopOnError();
			end
			assert (!(ackLast && wbCyc))
			else begin
				$display("wbCyc still high in the cycle after wbAck at %0t ns", $time);
				stopOnError();
			end
			assert (!wbCyc || (wbAdr[31:14] == '0 && wbAdr[1:0] == 2'b00))
			else begin
				$display("walker read %h outside the page tables at %0t ns", wbAdr, $time);
				stopOnError();
			end
		end
	end

	initial begin
		#((totalWalks * walkBudget + 500) * clkPeriod);
		$display("watchdog expired before all tests finished");
		stopOnError();
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stopOnError();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stopOnError();
		end
	endtask

	function automatic logic [31:0] makePte(input svPagingPkg::ppnT ppn, input logic [7:0] flags);
		return {2'b00, ppn, 2'b00, flags};
	endfunction

	function automatic logic [31:0] kiloPadr(input svPagingPkg::ppnT ppn, input logic [31:0] va);
		return {ppn, va[11:0]};
	endfunction

	function automatic logic [31:0] megaPadr(input svPagingPkg::ppnT ppn, input logic [31:0] va);
		return {ppn[19:10], va[21:0]};
	endfunction

	// table entry at {table ppn, index, 00}
	task automatic writePte(input svPagingPkg::ppnT tablePpn, input logic [9:0] idx,
			input logic [31:0] pte);
		logic [31:0] adr;
		adr = {tablePpn, idx, 2'b00};
		memory.mem[adr[13:2]] = pte;
	endtask

	// one request, result checked in the cycle after lookupValid
	task automatic lookup(input logic [31:0] vadr, input svPagingPkg::accessT acc,
			input logic expHit, input logic expFault, input logic [31:0] expPadr);
		@(posedge clk);
		#2;
		lookupValid = 1'b1;
		lookupVadr = vadr;
		lookupAccess = acc;
		@(posedge clk);
		#2;
		lookupValid = 1'b0;
		assert (lookupDone)
		else begin
			$display("lookupDone missing one cycle after lookup of %h", vadr);
			stopOnError();
		end
		checkVal("lookupHit", lookupHit, expHit);
		checkVal("lookupFault", lookupFault, expFault);
		if (expHit)
			checkVal("lookupPadr", lookupPadr, expPadr);
	endtask

	task automatic waitWalk(input int target, input int walks);
		int cycles;
		cycles = 0;
		while (fills + faults < target && cycles < walks * walkBudget) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		assert (fills + faults >= target)
		else begin
			$display("%0d walks did not end within %0d cycles", walks, cycles);
			stopOnError();
		end
	endtask

	// miss, then wait for the walk it started
	task automatic missAndWalk(input logic [31:0] vadr, input svPagingPkg::accessT acc,
			input logic expectFault);
		int target, faultsBefore;
		target = fills + faults + 1;
		faultsBefore = faults;
		lookup(vadr, acc, 1'b0, 1'b0, '0);
		waitWalk(target, 1);
		checkVal("walkFault count", faults - faultsBefore, expectFault);
		if (expectFault)
			checkVal("faultVadr", lastFault, {vadr[31:12], 12'h000});
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	// outputs that reset must clear
	task automatic resetStateTest();
		checkVal("lookupDone", lookupDone, 1'b0);
		checkVal("wbCyc", wbCyc, 1'b0);
		checkVal("wbStb", wbStb, 1'b0);
		checkVal("walkFault", walkFault, 1'b0);
	endtask

	task automatic kilopageTest();
		writePte(rootPpn, 10'h010, makePte(20'h00002, flagV));	// pointer to table 2
		writePte(20'h00002, 10'h005, makePte(20'h12345, flagsRwad));
		missAndWalk(32'h0400_5abc, svPagingPkg::ACC_READ, 1'b0);
		lookup(32'h0400_5abc, svPagingPkg::ACC_READ, 1'b1, 1'b0, kiloPadr(20'h12345, 32'h0400_5abc));
	endtask

	task automatic megapageTest();
		writePte(rootPpn, 10'h040, makePte(20'h80000, flagsRwad));	// aligned 4 MiB leaf
		missAndWalk(32'h1012_3456, svPagingPkg::ACC_READ, 1'b0);
		lookup(32'h1012_3456, svPagingPkg::ACC_READ, 1'b1, 1'b0, megaPadr(20'h80000, 32'h1012_3456));
		lookup(32'h103f_fffc, svPagingPkg::ACC_WRITE, 1'b1, 1'b0, megaPadr(20'h80000, 32'h103f_fffc));
	endtask

	task automatic walkFaultTest();
		logic [31:0] pages [5];
		pages = '{32'h0800_1000, 32'h0800_2004, 32'h0c00_5123, 32'h0800_3008, 32'h0800_4ffc};
		writePte(rootPpn, 10'h020, makePte(20'h00003, flagV));
		writePte(20'h00003, 10'h001, makePte(20'h00111, flagR | flagA));	// V clear
		writePte(20'h00003, 10'h002, makePte(20'h00112, flagV | flagW | flagA | flagD));
		writePte(rootPpn, 10'h030, makePte(20'h40001, flagV | flagR | flagA));	// misaligned
		writePte(20'h00003, 10'h003, makePte(20'h00113, flagV));	// pointer at level 0
		writePte(20'h00003, 10'h004, makePte(20'h00114, flagV | flagR));	// A clear
		foreach (pages[i]) begin
			missAndWalk(pages[i], svPagingPkg::ACC_READ, 1'b1);
			missAndWalk(pages[i], svPagingPkg::ACC_READ, 1'b1);	// still not cached
		end
	endtask

	task automatic permissionTest();
		writePte(20'h00002, 10'h006, makePte(20'h00a06, flagV | flagR | flagA));	// read only
		writePte(20'h00002, 10'h007, makePte(20'h00a07, flagV | flagR | flagW | flagA));	// D clear
		missAndWalk(32'h0400_6010, svPagingPkg::ACC_WRITE, 1'b0);
		lookup(32'h0400_6010, svPagingPkg::ACC_WRITE, 1'b0, 1'b1, '0);
		missAndWalk(32'h0400_7020, svPagingPkg::ACC_WRITE, 1'b0);
		lookup(32'h0400_7020, svPagingPkg::ACC_WRITE, 1'b0, 1'b1, '0);
		lookup(32'h0400_7020, svPagingPkg::ACC_READ, 1'b1, 1'b0, kiloPadr(20'h00a07, 32'h0400_7020));
	endtask

	// five pages through four entries, the first one filled is the victim
	task automatic capacityFlushTest();
		logic [31:0] va [5];
		int target;
		for (int i = 0; i < 5; i++) begin
			va[i] = {10'h010, 10'(10'h010 + i), 12'h3c0};
			writePte(20'h00002, 10'(10'h010 + i), makePte(20'(20'h00300 + i), flagsRwad));
		end
		for (int i = 0; i < 5; i++)
			missAndWalk(va[i], svPagingPkg::ACC_READ, 1'b0);
		for (int i = 1; i < 5; i++)
			lookup(va[i], svPagingPkg::ACC_READ, 1'b1, 1'b0, kiloPadr(20'(20'h00300 + i), va[i]));
		missAndWalk(va[0], svPagingPkg::ACC_READ, 1'b0);	// evicted, refilled here
		@(posedge clk);
		#2;
		flushTlb = 1'b1;
		@(posedge clk);
		#2;
		flushTlb = 1'b0;
		target = fills + faults + 5;
		for (int i = 0; i < 5; i++)
			lookup(va[i], svPagingPkg::ACC_READ, 1'b0, 1'b0, '0);
		waitWalk(target, 5);	// drain the walks the misses queued
	endtask

	// misses pile up in the queue behind a slow walker
	task automatic backPressureTest();
		logic [31:0] va [4];
		int target;
		for (int i = 0; i < 4; i++) begin
			va[i] = {10'h020, 10'(10'h020 + i), 12'(12'h010 * i)};
			writePte(20'h00003, 10'(10'h020 + i), makePte(20'(20'h005a0 + i), flagsRwad));
		end
		target = fills + faults + 4;
		for (int i = 0; i < 4; i++)
			lookup(va[i], svPagingPkg::ACC_READ, 1'b0, 1'b0, '0);
		waitWalk(target, 4);
		for (int i = 0; i < 4; i++)
			lookup(va[i], svPagingPkg::ACC_READ, 1'b1, 1'b0, kiloPadr(20'(20'h005a0 + i), va[i]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		flushTlb = 1'b0;
		lookupValid = 1'b0;
		lookupVadr = '0;
		lookupAccess = svPagingPkg::ACC_READ;
		satpPpn = rootPpn;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		resetStateTest();
		kilopageTest();
		megapageTest();
		walkFaultTest();
		permissionTest();
		capacityFlushTest();
		backPressureTest();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* src.f */
source/svPagingPkg.sv
source/wbBusPkg.sv
source/walkReqIf.sv
source/tlb.sv
source/walkQueue.sv
source/hptw.sv
source/mmuTop.sv
verification/mmuMemModel.sv
verification/mmuTb.sv
